// ==== design/lane_seq_pkg.sv ====
// Sizes, queue indices and types shared by the lane sequencer blocks
// The lane count is fixed at 4; LANE_IDX_W and the split logic assume a power of two
package lane_seq_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned NR_LANES   = 4;
  localparam int unsigned LANE_IDX_W = 2;
  localparam int unsigned NR_VINSN   = 8;
  localparam int unsigned NR_OPQ     = 5;
  localparam int unsigned REQ_DEPTH  = 8;
  localparam int unsigned REQ_PTR_W  = 3;
  localparam int unsigned REQ_CNT_W  = 4;

  // Position of each operand queue in the per-queue ports
  localparam int unsigned ALU_A  = 0;
  localparam int unsigned ALU_B  = 1;
  localparam int unsigned MFPU_A = 2;
  localparam int unsigned MFPU_B = 3;
  localparam int unsigned MFPU_C = 4;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [LANE_IDX_W-1:0] lane_id_t;
  typedef logic [2:0]            vid_t;
  typedef logic [NR_VINSN-1:0]   vid_mask_t;
  typedef logic [15:0]           vl_t;
  typedef logic [4:0]            vreg_t;
  typedef logic [NR_OPQ-1:0]     opq_mask_t;

  typedef enum logic [0:0] {
    VFU_ALU  = 1'b0,
    VFU_MFPU = 1'b1
  } vfu_e;

  // Packed request, from the MSB down:
  // ID, unit, vl, vstart, vs1, vs2, vd, use_vs1, use_vs2, use_vd
  localparam int unsigned REQ_W = $bits(vid_t) + $bits(vfu_e) + 2 * $bits(vl_t) +
                                  3 * $bits(vreg_t) + 3;

  typedef logic [REQ_W-1:0] req_word_t;

endpackage

// ==== design/req_intake.sv ====
// Accepts each broadcast request once, even while the main sequencer holds it valid
// A repeated ID is only accepted again after valid has been low for a cycle
`timescale 1ns/1ps

module req_intake (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  input  lane_seq_pkg::vid_t      req_id_i,
  input  lane_seq_pkg::vfu_e      req_vfu_i,
  input  lane_seq_pkg::vl_t       req_vl_i,
  input  lane_seq_pkg::vl_t       req_vstart_i,
  input  lane_seq_pkg::vreg_t     req_vs1_i,
  input  lane_seq_pkg::vreg_t     req_vs2_i,
  input  lane_seq_pkg::vreg_t     req_vd_i,
  input  logic                    req_use_vs1_i,
  input  logic                    req_use_vs2_i,
  input  logic                    req_use_vd_i,
  input  logic                    full_i,
  output logic                    push_o,
  output lane_seq_pkg::req_word_t word_o
);
  import lane_seq_pkg::*;

  vid_t last_id_q;
  logic sync_mask_q;
  logic valid_msk;

  // A held broadcast with the ID we already took is hidden from the buffer
  assign valid_msk = req_valid_i & ~(sync_mask_q & (req_id_i == last_id_q));
  assign push_o    = valid_msk & ~full_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_id_q   <= '0;
      sync_mask_q <= 1'b0;
    end else begin
      if (push_o) begin
        last_id_q   <= req_id_i;
        sync_mask_q <= 1'b1;
      end else if (!req_valid_i) begin
        // Broadcast is over, the next request may reuse the ID
        sync_mask_q <= 1'b0;
      end
    end
  end

  assign word_o = {req_id_i, req_vfu_i, req_vl_i, req_vstart_i,
                   req_vs1_i, req_vs2_i, req_vd_i,
                   req_use_vs1_i, req_use_vs2_i, req_use_vd_i};

endmodule

// ==== design/req_buffer.sv ====
// Fall-through request FIFO of REQ_DEPTH entries
// An empty buffer shows the incoming word at the head in the same cycle
// Pushes while full and pops while empty are ignored
`timescale 1ns/1ps

module req_buffer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  lane_seq_pkg::req_word_t word_i,
  input  logic                    pop_i,
  output logic                    full_o,
  output logic                    empty_o,
  output lane_seq_pkg::req_word_t head_o
);
  import lane_seq_pkg::*;

  req_word_t            mem_q [REQ_DEPTH];
  logic [REQ_PTR_W-1:0] wr_ptr_q;
  logic [REQ_PTR_W-1:0] rd_ptr_q;
  logic [REQ_CNT_W-1:0] cnt_q;
  logic                 bypass;
  logic                 push;
  logic                 pop;

  assign bypass  = (cnt_q == '0);
  assign full_o  = (cnt_q == REQ_CNT_W'(REQ_DEPTH));
  assign empty_o = bypass & ~push_i;
  assign head_o  = bypass ? word_i : mem_q[rd_ptr_q];

  assign push = push_i & ~full_o;
  assign pop  = pop_i & ~empty_o;

  // On a pass-through both pointers move together, so the stored copy is never read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + REQ_PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + REQ_PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + REQ_CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - REQ_CNT_W'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= word_i;
    end
  end

endmodule

// ==== design/lane_dispatch.sv ====
// Issues the head request to the lane ALU or MFPU and posts its operand commands
// Operand commands are combinational and land in the slots at the next edge
// A request stalls as a whole while any slot of its unit is still occupied
`timescale 1ns/1ps

module lane_dispatch (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  lane_seq_pkg::lane_id_t                        lane_id_i,
  input  lane_seq_pkg::req_word_t                       head_i,
  input  logic                                          empty_i,
  output logic                                          pop_o,
  input  lane_seq_pkg::vid_mask_t                       vinsn_running_i,
  input  lane_seq_pkg::opq_mask_t                       slot_busy_i,
  output lane_seq_pkg::opq_mask_t                       slot_push_o,
  output lane_seq_pkg::vid_t                            cmd_id_o,
  output lane_seq_pkg::vreg_t [lane_seq_pkg::NR_OPQ-1:0] cmd_vs_o,
  output lane_seq_pkg::vl_t                             cmd_vl_o,
  output lane_seq_pkg::vl_t                             cmd_vstart_o,
  output logic                                          vfu_valid_o,
  output lane_seq_pkg::vfu_e                            vfu_unit_o,
  output lane_seq_pkg::vid_t                            vfu_id_o,
  output lane_seq_pkg::vl_t                             vfu_vl_o,
  output lane_seq_pkg::vl_t                             vfu_vstart_o,
  output lane_seq_pkg::vreg_t                           vfu_vd_o,
  input  lane_seq_pkg::vid_mask_t                       alu_done_i,
  input  lane_seq_pkg::vid_mask_t                       mfpu_done_i,
  output lane_seq_pkg::vid_mask_t                       vinsn_done_o,
  output logic                                          alu_vinsn_done_o,
  output logic                                          mfpu_vinsn_done_o
);
  import lane_seq_pkg::*;

  // Fields of the head request
  vid_t  req_id;
  logic  req_vfu_bit;
  vfu_e  req_vfu;
  vl_t   req_vl;
  vl_t   req_vstart;
  vreg_t req_vs1;
  vreg_t req_vs2;
  vreg_t req_vd;
  logic  req_use_vs1;
  logic  req_use_vs2;
  logic  req_use_vd;

  vl_t       lane_vl;
  vl_t       lane_vstart;
  logic      stall;
  logic      take;
  logic      drop;
  logic      mute;
  logic      issue;
  vid_mask_t running_live;
  vid_mask_t running_d;
  vid_mask_t running_q;
  vid_mask_t done_d;

  // Elements of a length that fall on this lane, with element i on lane i % NR_LANES
  function automatic vl_t lane_share(vl_t total, lane_id_t lane);
    vl_t share;
    share = vl_t'(total / NR_LANES);
    if (lane < total[LANE_IDX_W-1:0]) begin
      share = share + vl_t'(1);
    end
    return share;
  endfunction

  assign {req_id, req_vfu_bit, req_vl, req_vstart, req_vs1, req_vs2, req_vd,
          req_use_vs1, req_use_vs2, req_use_vd} = head_i;
  assign req_vfu = vfu_e'(req_vfu_bit);

  assign lane_vl     = lane_share(req_vl, lane_id_i);
  assign lane_vstart = lane_share(req_vstart, lane_id_i);

  ////////////////////
  // Accept
  ////////////////////

  always_comb begin
    if (req_vfu == VFU_ALU) begin
      stall = slot_busy_i[ALU_A] | slot_busy_i[ALU_B];
    end else begin
      stall = slot_busy_i[MFPU_A] | slot_busy_i[MFPU_B] | slot_busy_i[MFPU_C];
    end
  end

  // Bits the main sequencer has retired are dropped before the ID check
  assign running_live = running_q & vinsn_running_i;

  assign take  = ~empty_i & ~stall;
  assign drop  = take & running_live[req_id];
  assign mute  = take & ~drop & (lane_vl == '0);
  assign issue = take & ~drop & ~mute;
  assign pop_o = take;

  always_comb begin
    running_d = running_live;
    done_d    = alu_done_i | mfpu_done_i;
    if (issue) begin
      running_d[req_id] = 1'b1;
    end
    // Nothing of this instruction runs here, so it is finished right away
    if (mute) begin
      done_d[req_id] = 1'b1;
    end
  end

  ////////////////////
  // Operand commands
  ////////////////////

  always_comb begin
    cmd_vs_o         = '0;
    cmd_vs_o[ALU_A]  = req_vs1;
    cmd_vs_o[ALU_B]  = req_vs2;
    cmd_vs_o[MFPU_A] = req_vs1;
    cmd_vs_o[MFPU_B] = req_vs2;
    cmd_vs_o[MFPU_C] = req_vd;

    slot_push_o = '0;
    if (issue) begin
      if (req_vfu == VFU_ALU) begin
        slot_push_o[ALU_A] = req_use_vs1;
        slot_push_o[ALU_B] = req_use_vs2;
      end else begin
        slot_push_o[MFPU_A] = req_use_vs1;
        slot_push_o[MFPU_B] = req_use_vs2;
        slot_push_o[MFPU_C] = req_use_vd;
      end
    end
  end

  assign cmd_id_o     = req_id;
  assign cmd_vl_o     = lane_vl;
  assign cmd_vstart_o = lane_vstart;

  ////////////////////
  // Registered state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q         <= '0;
      vfu_valid_o       <= 1'b0;
      vinsn_done_o      <= '0;
      alu_vinsn_done_o  <= 1'b0;
      mfpu_vinsn_done_o <= 1'b0;
    end else begin
      running_q         <= running_d;
      vfu_valid_o       <= issue;
      vinsn_done_o      <= done_d;
      alu_vinsn_done_o  <= |alu_done_i;
      mfpu_vinsn_done_o <= |mfpu_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      vfu_unit_o   <= req_vfu;
      vfu_id_o     <= req_id;
      vfu_vl_o     <= lane_vl;
      vfu_vstart_o <= lane_vstart;
      vfu_vd_o     <= req_vd;
    end
  end

endmodule

// ==== design/operand_cmd_slots.sv ====
// One registered operand command per queue, held until the operand requester takes it
// A push in the same cycle as ready wins, so back-to-back commands need no gap
`timescale 1ns/1ps

module operand_cmd_slots (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  lane_seq_pkg::opq_mask_t                       push_i,
  input  lane_seq_pkg::vid_t                            cmd_id_i,
  input  lane_seq_pkg::vreg_t [lane_seq_pkg::NR_OPQ-1:0] cmd_vs_i,
  input  lane_seq_pkg::vl_t                             cmd_vl_i,
  input  lane_seq_pkg::vl_t                             cmd_vstart_i,
  input  lane_seq_pkg::opq_mask_t                       opreq_ready_i,
  output lane_seq_pkg::opq_mask_t                       opreq_valid_o,
  output lane_seq_pkg::vid_t  [lane_seq_pkg::NR_OPQ-1:0] opreq_id_o,
  output lane_seq_pkg::vreg_t [lane_seq_pkg::NR_OPQ-1:0] opreq_vs_o,
  output lane_seq_pkg::vl_t   [lane_seq_pkg::NR_OPQ-1:0] opreq_vl_o,
  output lane_seq_pkg::vl_t   [lane_seq_pkg::NR_OPQ-1:0] opreq_vstart_o
);
  import lane_seq_pkg::*;

  // Occupancy per slot, also read back by the dispatcher as its busy mask
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opreq_valid_o <= '0;
    end else begin
      opreq_valid_o <= push_i | (opreq_valid_o & ~opreq_ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NR_OPQ; q++) begin
      if (push_i[q]) begin
        opreq_id_o[q]     <= cmd_id_i;
        opreq_vs_o[q]     <= cmd_vs_i[q];
        opreq_vl_o[q]     <= cmd_vl_i;
        opreq_vstart_o[q] <= cmd_vstart_i;
      end
    end
  end

endmodule

// ==== design/lane_sequencer.sv ====
// Instruction sequencer of one lane: intake, request buffer, dispatcher, operand slots
// Request to VFU outputs takes one edge when the buffer is empty and nothing stalls
`timescale 1ns/1ps

module lane_sequencer (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  lane_seq_pkg::lane_id_t                        lane_id_i,
  // Main sequencer
  input  logic                                          req_valid_i,
  input  lane_seq_pkg::vid_t                            req_id_i,
  input  lane_seq_pkg::vfu_e                            req_vfu_i,
  input  lane_seq_pkg::vl_t                             req_vl_i,
  input  lane_seq_pkg::vl_t                             req_vstart_i,
  input  lane_seq_pkg::vreg_t                           req_vs1_i,
  input  lane_seq_pkg::vreg_t                           req_vs2_i,
  input  lane_seq_pkg::vreg_t                           req_vd_i,
  input  logic                                          req_use_vs1_i,
  input  logic                                          req_use_vs2_i,
  input  logic                                          req_use_vd_i,
  output logic                                          req_ready_o,
  input  lane_seq_pkg::vid_mask_t                       vinsn_running_i,
  output lane_seq_pkg::vid_mask_t                       vinsn_done_o,
  // Operand requester
  input  lane_seq_pkg::opq_mask_t                       opreq_ready_i,
  output lane_seq_pkg::opq_mask_t                       opreq_valid_o,
  output lane_seq_pkg::vid_t  [lane_seq_pkg::NR_OPQ-1:0] opreq_id_o,
  output lane_seq_pkg::vreg_t [lane_seq_pkg::NR_OPQ-1:0] opreq_vs_o,
  output lane_seq_pkg::vl_t   [lane_seq_pkg::NR_OPQ-1:0] opreq_vl_o,
  output lane_seq_pkg::vl_t   [lane_seq_pkg::NR_OPQ-1:0] opreq_vstart_o,
  // Lane functional units
  output logic                                          vfu_valid_o,
  output lane_seq_pkg::vfu_e                            vfu_unit_o,
  output lane_seq_pkg::vid_t                            vfu_id_o,
  output lane_seq_pkg::vl_t                             vfu_vl_o,
  output lane_seq_pkg::vl_t                             vfu_vstart_o,
  output lane_seq_pkg::vreg_t                           vfu_vd_o,
  input  lane_seq_pkg::vid_mask_t                       alu_done_i,
  input  lane_seq_pkg::vid_mask_t                       mfpu_done_i,
  output logic                                          alu_vinsn_done_o,
  output logic                                          mfpu_vinsn_done_o
);
  import lane_seq_pkg::*;

  logic                   push;
  req_word_t              word;
  logic                   full;
  logic                   empty;
  req_word_t              head;
  logic                   pop;
  opq_mask_t              slot_push;
  vid_t                   cmd_id;
  vreg_t [NR_OPQ-1:0]     cmd_vs;
  vl_t                    cmd_vl;
  vl_t                    cmd_vstart;

  assign req_ready_o = ~full;

  req_intake u_intake (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_id_i      (req_id_i),
    .req_vfu_i     (req_vfu_i),
    .req_vl_i      (req_vl_i),
    .req_vstart_i  (req_vstart_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_vd_i      (req_vd_i),
    .req_use_vs1_i (req_use_vs1_i),
    .req_use_vs2_i (req_use_vs2_i),
    .req_use_vd_i  (req_use_vd_i),
    .full_i        (full),
    .push_o        (push),
    .word_o        (word)
  );

  req_buffer u_buffer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .word_i  (word),
    .pop_i   (pop),
    .full_o  (full),
    .empty_o (empty),
    .head_o  (head)
  );

  lane_dispatch u_dispatch (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lane_id_i         (lane_id_i),
    .head_i            (head),
    .empty_i           (empty),
    .pop_o             (pop),
    .vinsn_running_i   (vinsn_running_i),
    .slot_busy_i       (opreq_valid_o),
    .slot_push_o       (slot_push),
    .cmd_id_o          (cmd_id),
    .cmd_vs_o          (cmd_vs),
    .cmd_vl_o          (cmd_vl),
    .cmd_vstart_o      (cmd_vstart),
    .vfu_valid_o       (vfu_valid_o),
    .vfu_unit_o        (vfu_unit_o),
    .vfu_id_o          (vfu_id_o),
    .vfu_vl_o          (vfu_vl_o),
    .vfu_vstart_o      (vfu_vstart_o),
    .vfu_vd_o          (vfu_vd_o),
    .alu_done_i        (alu_done_i),
    .mfpu_done_i       (mfpu_done_i),
    .vinsn_done_o      (vinsn_done_o),
    .alu_vinsn_done_o  (alu_vinsn_done_o),
    .mfpu_vinsn_done_o (mfpu_vinsn_done_o)
  );

  operand_cmd_slots u_slots (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (slot_push),
    .cmd_id_i       (cmd_id),
    .cmd_vs_i       (cmd_vs),
    .cmd_vl_i       (cmd_vl),
    .cmd_vstart_i   (cmd_vstart),
    .opreq_ready_i  (opreq_ready_i),
    .opreq_valid_o  (opreq_valid_o),
    .opreq_id_o     (opreq_id_o),
    .opreq_vs_o     (opreq_vs_o),
    .opreq_vl_o     (opreq_vl_o),
    .opreq_vstart_o (opreq_vstart_o)
  );

endmodule

// ==== verif/tb_clock.sv ====
// Free-running 8 ns clock and an active-low reset held for the first 2 rising edges
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== verif/lane_sequencer_tb.sv ====
// Directed tests of one lane sequencer; inputs change 1 ns after the rising edge
// Issues and slot activity are sampled at the falling edge by a monitor
// Instruction IDs are 3 bits, so back-pressure requests reuse IDs after 8
`timescale 1ns/1ps

module lane_sequencer_tb;
  import lane_seq_pkg::*;

  logic               clk;
  logic               rst_n;
  lane_id_t           lane_id;
  logic               req_valid;
  vid_t               req_id;
  vfu_e               req_vfu;
  vl_t                req_vl;
  vl_t                req_vstart;
  vreg_t              req_vs1;
  vreg_t              req_vs2;
  vreg_t              req_vd;
  logic               req_use_vs1;
  logic               req_use_vs2;
  logic               req_use_vd;
  logic               req_ready;
  vid_mask_t          vinsn_running;
  vid_mask_t          vinsn_done;
  opq_mask_t          opreq_ready;
  opq_mask_t          opreq_valid;
  vid_t  [NR_OPQ-1:0] opreq_id;
  vreg_t [NR_OPQ-1:0] opreq_vs;
  vl_t   [NR_OPQ-1:0] opreq_vl;
  vl_t   [NR_OPQ-1:0] opreq_vstart;
  logic               vfu_valid;
  vfu_e               vfu_unit;
  vid_t               vfu_id;
  vl_t                vfu_vl;
  vl_t                vfu_vstart;
  vreg_t              vfu_vd;
  vid_mask_t          alu_done;
  vid_mask_t          mfpu_done;
  logic               alu_vinsn_done;
  logic               mfpu_vinsn_done;

  int          errors;
  int          checks;
  int          tests;
  logic [31:0] lfsr_state;
  vid_t        issued_id[$];
  vl_t         issued_vl[$];
  vl_t         issued_vstart[$];
  opq_mask_t   slot_seen;
  vid_t        exp_id[$];
  vl_t         exp_vl[$];
  vl_t         exp_vstart[$];

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lane_sequencer dut0 (
    .clk_i (clk), .rst_ni (rst_n), .lane_id_i (lane_id),
    .req_valid_i (req_valid), .req_id_i (req_id), .req_vfu_i (req_vfu),
    .req_vl_i (req_vl), .req_vstart_i (req_vstart),
    .req_vs1_i (req_vs1), .req_vs2_i (req_vs2), .req_vd_i (req_vd),
    .req_use_vs1_i (req_use_vs1), .req_use_vs2_i (req_use_vs2),
    .req_use_vd_i (req_use_vd), .req_ready_o (req_ready),
    .vinsn_running_i (vinsn_running), .vinsn_done_o (vinsn_done),
    .opreq_ready_i (opreq_ready), .opreq_valid_o (opreq_valid),
    .opreq_id_o (opreq_id), .opreq_vs_o (opreq_vs), .opreq_vl_o (opreq_vl),
    .opreq_vstart_o (opreq_vstart),
    .vfu_valid_o (vfu_valid), .vfu_unit_o (vfu_unit), .vfu_id_o (vfu_id),
    .vfu_vl_o (vfu_vl), .vfu_vstart_o (vfu_vstart), .vfu_vd_o (vfu_vd),
    .alu_done_i (alu_done), .mfpu_done_i (mfpu_done),
    .alu_vinsn_done_o (alu_vinsn_done), .mfpu_vinsn_done_o (mfpu_vinsn_done)
  );

  // Issue monitor, one entry per vfu_valid_o pulse
  always @(negedge clk) begin
    if (vfu_valid) begin
      issued_id.push_back(vfu_id);
      issued_vl.push_back(vfu_vl);
      issued_vstart.push_back(vfu_vstart);
    end
    slot_seen = slot_seen | opreq_valid;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Element i lives on lane i % NR_LANES, so count the indices below total on this lane
  function automatic vl_t lane_elems(vl_t total, int lane);
    vl_t n;
    n = '0;
    for (int i = 0; i < int'(total); i++) begin
      if (i % int'(NR_LANES) == lane) begin
        n = n + 16'd1;
      end
    end
    return n;
  endfunction

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[14:0], fb};
    end
    return val;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_vl(string name, vl_t got, vl_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_vid(string name, vid_t got, vid_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_mask(string name, vid_mask_t got, vid_mask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_vreg(string name, vreg_t got, vreg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_unit(string name, vfu_e got, vfu_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_issue_count(int exp);
    checks++;
    if (issued_id.size() != exp) begin
      errors++;
      $display("ERROR: saw %0d issued instructions where %0d were expected",
               issued_id.size(), exp);
    end
  endtask

  ////////////////////
  // Drivers
  ////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_monitor();
    issued_id.delete();
    issued_vl.delete();
    issued_vstart.delete();
    slot_seen = '0;
  endtask

  task automatic drive_req(vid_t id, vfu_e unit, vl_t vl, vl_t vstart, vreg_t vs1,
                           vreg_t vs2, vreg_t vd, logic use1, logic use2, logic use3);
    req_valid   = 1'b1;
    req_id      = id;
    req_vfu     = unit;
    req_vl      = vl;
    req_vstart  = vstart;
    req_vs1     = vs1;
    req_vs2     = vs2;
    req_vd      = vd;
    req_use_vs1 = use1;
    req_use_vs2 = use2;
    req_use_vd  = use3;
  endtask

  // Holds valid until a cycle with ready high has passed its edge, then drops it
  task automatic wait_accept(int limit);
    logic ready;
    int   cycles;
    ready  = 1'b0;
    cycles = 0;
    while (!ready && cycles < limit) begin
      ready = req_ready;
      next_cycle();
      cycles++;
    end
    req_valid = 1'b0;
    if (!ready) begin
      errors++;
      $display("ERROR: request with ID %0d was not accepted in %0d cycles", req_id, limit);
    end
  endtask

  task automatic wait_issues(int n, int limit);
    int cycles;
    cycles = 0;
    while (issued_id.size() < n && cycles < limit) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (issued_id.size() < n) begin
      errors++;
      $display("ERROR: only %0d of %0d issues seen after %0d cycles",
               issued_id.size(), n, limit);
    end
  endtask

  task automatic finish_test(string name, int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic alu_issue_test();
    int start_errors;
    start_errors = errors;
    check_flag("req_ready_o after reset", req_ready, 1'b1);
    check_flag("vfu_valid_o after reset", vfu_valid, 1'b0);
    check_flag("opreq_valid_o after reset", |opreq_valid, 1'b0);
    check_mask("vinsn_done_o after reset", vinsn_done, '0);
    clear_monitor();
    lane_id = 2'd1;
    drive_req(3'd1, VFU_ALU, 16'd10, 16'd5, 5'd3, 5'd7, 5'd9, 1'b1, 1'b1, 1'b0);
    wait_accept(10);
    wait_issues(1, 10);
    check_vid("vfu_id_o", vfu_id, 3'd1);
    check_unit("vfu_unit_o", vfu_unit, VFU_ALU);
    check_vl("vfu_vl_o", vfu_vl, lane_elems(16'd10, 1));
    check_vl("vfu_vstart_o", vfu_vstart, lane_elems(16'd5, 1));
    check_vreg("vfu_vd_o", vfu_vd, 5'd9);
    check_flag("opreq_valid_o[ALU_A]", opreq_valid[ALU_A], 1'b1);
    check_flag("opreq_valid_o[ALU_B]", opreq_valid[ALU_B], 1'b1);
    check_vid("opreq_id_o[ALU_A]", opreq_id[ALU_A], 3'd1);
    check_vreg("opreq_vs_o[ALU_A]", opreq_vs[ALU_A], 5'd3);
    check_vreg("opreq_vs_o[ALU_B]", opreq_vs[ALU_B], 5'd7);
    check_vl("opreq_vl_o[ALU_B]", opreq_vl[ALU_B], 16'd3);
    check_vl("opreq_vstart_o[ALU_A]", opreq_vstart[ALU_A], lane_elems(16'd5, 1));
    next_cycle();
    next_cycle();
    check_flag("MFPU slots used", |slot_seen[MFPU_C:MFPU_A], 1'b0);
    finish_test("alu_issue", start_errors);
  endtask

  task automatic held_broadcast_test();
    int start_errors;
    start_errors = errors;
    clear_monitor();
    drive_req(3'd2, VFU_ALU, 16'd8, 16'd0, 5'd1, 5'd2, 5'd3, 1'b1, 1'b1, 1'b0);
    repeat (6) next_cycle();
    req_valid = 1'b0;
    repeat (3) next_cycle();
    check_issue_count(1);
    drive_req(3'd2, VFU_ALU, 16'd8, 16'd0, 5'd1, 5'd2, 5'd3, 1'b1, 1'b1, 1'b0);
    wait_accept(10);
    wait_issues(2, 10);
    check_issue_count(2);
    finish_test("held_broadcast", start_errors);
  endtask

  task automatic back_pressure_test();
    int  start_errors;
    vl_t vl;
    vl_t vst;
    start_errors = errors;
    lane_id      = 2'd2;
    // Let the ALU slots filled by the previous test drain first
    next_cycle();
    opreq_ready  = '0;
    exp_id.delete();
    exp_vl.delete();
    exp_vstart.delete();
    // This one parks in ALU_A and holds every later ALU request
    clear_monitor();
    drive_req(3'd0, VFU_ALU, 16'd8, 16'd0, 5'd4, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0);
    wait_accept(10);
    wait_issues(1, 10);
    next_cycle();
    clear_monitor();
    for (int k = 1; k <= 9; k++) begin
      vl  = rand_bits(8) + 16'd4;
      vst = rand_bits(5);
      exp_id.push_back(vid_t'(k));
      exp_vl.push_back(lane_elems(vl, 2));
      exp_vstart.push_back(lane_elems(vst, 2));
      drive_req(vid_t'(k), VFU_ALU, vl, vst, vreg_t'(k), 5'd0, 5'd0, 1'b1, 1'b0, 1'b0);
      if (k < 9) begin
        wait_accept(10);
      end
    end
    check_flag("req_ready_o with 8 stored", req_ready, 1'b0);
    next_cycle();
    next_cycle();
    check_flag("req_ready_o while stalled", req_ready, 1'b0);
    check_issue_count(0);
    opreq_ready = '1;
    wait_accept(40);
    wait_issues(9, 80);
    for (int i = 0; i < issued_id.size() && i < 9; i++) begin
      check_vid("vfu_id_o", issued_id[i], exp_id[i]);
      check_vl("vfu_vl_o", issued_vl[i], exp_vl[i]);
      check_vl("vfu_vstart_o", issued_vstart[i], exp_vstart[i]);
    end
    finish_test("back_pressure", start_errors);
  endtask

  task automatic muted_test();
    int start_errors;
    start_errors = errors;
    lane_id      = 2'd3;
    next_cycle();
    clear_monitor();
    drive_req(3'd6, VFU_MFPU, 16'd2, 16'd0, 5'd1, 5'd2, 5'd3, 1'b1, 1'b1, 1'b1);
    wait_accept(10);
    // Done is registered at the same edge that pops the muted request
    check_mask("vinsn_done_o", vinsn_done, 8'h40);
    repeat (4) next_cycle();
    check_issue_count(0);
    check_flag("operand slots used", |slot_seen, 1'b0);
    finish_test("muted", start_errors);
  endtask

  task automatic done_running_test();
    int start_errors;
    start_errors = errors;
    clear_monitor();
    alu_done = 8'h10;
    next_cycle();
    alu_done  = '0;
    mfpu_done = 8'h08;
    check_mask("vinsn_done_o", vinsn_done, 8'h10);
    check_flag("alu_vinsn_done_o", alu_vinsn_done, 1'b1);
    check_flag("mfpu_vinsn_done_o", mfpu_vinsn_done, 1'b0);
    next_cycle();
    mfpu_done = '0;
    check_mask("vinsn_done_o", vinsn_done, 8'h08);
    check_flag("alu_vinsn_done_o", alu_vinsn_done, 1'b0);
    check_flag("mfpu_vinsn_done_o", mfpu_vinsn_done, 1'b1);
    next_cycle();
    check_mask("vinsn_done_o", vinsn_done, 8'h00);
    vinsn_running = 8'h20;
    drive_req(3'd5, VFU_ALU, 16'd8, 16'd0, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b0);
    wait_accept(10);
    wait_issues(1, 10);
    check_vid("vfu_id_o", vfu_id, 3'd5);
    next_cycle();
    drive_req(3'd5, VFU_ALU, 16'd8, 16'd0, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b0);
    wait_accept(10);
    repeat (4) next_cycle();
    check_issue_count(1);
    vinsn_running = '0;
    next_cycle();
    drive_req(3'd5, VFU_MFPU, 16'd8, 16'd6, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b1);
    wait_accept(10);
    wait_issues(2, 10);
    check_issue_count(2);
    check_unit("vfu_unit_o", vfu_unit, VFU_MFPU);
    check_flag("opreq_valid_o[MFPU_A]", opreq_valid[MFPU_A], 1'b0);
    check_flag("opreq_valid_o[MFPU_C]", opreq_valid[MFPU_C], 1'b1);
    check_vreg("opreq_vs_o[MFPU_C]", opreq_vs[MFPU_C], 5'd3);
    check_vl("opreq_vstart_o[MFPU_C]", opreq_vstart[MFPU_C], lane_elems(16'd6, 3));
    finish_test("done_running", start_errors);
  endtask

  initial begin
    int cycles;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    lfsr_state    = 32'h76a70580;
    lane_id       = '0;
    vinsn_running = '0;
    opreq_ready   = '1;
    alu_done      = '0;
    mfpu_done     = '0;
    drive_req('0, VFU_ALU, '0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    req_valid     = 1'b0;
    cycles        = 0;
    while (rst_n !== 1'b1 && cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("ERROR: reset was never released");
    end
    next_cycle();
    alu_issue_test();
    held_broadcast_test();
    back_pressure_test();
    muted_test();
    done_running_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/lane_seq_pkg.sv
design/req_intake.sv
design/req_buffer.sv
design/lane_dispatch.sv
design/operand_cmd_slots.sv
design/lane_sequencer.sv
verif/tb_clock.sv
verif/lane_sequencer_tb.sv

// ==== Makefile ====
# Verilator build and run of the lane sequencer testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module lane_sequencer_tb \
		-Mdir $(OBJ_DIR) -o sim_tb
	./$(OBJ_DIR)/sim_tb | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
